/* files.f */
+incdir+bench
rtl/mips_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/branch_resolve.sv
rtl/issue_credit.sv
rtl/decode_stage_top.sv
bench/decode_stage_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/instr_decode.sv
      - rtl/reg_file.sv
      - rtl/branch_resolve.sv
      - rtl/issue_credit.sv
      - rtl/decode_stage_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/decode_stage_tb.sv

/* bench/decode_vectors.svh */
// Columns are instr, pc, br_kind, rs, rt, rd, link_reg, funct, sa, is_rtype, ext_imm,
// taken, target, link_val, then the write-back addr and data driven while the op
// is issued (addr 0 = none)
localparam int N_VEC = 16;

task automatic load_vectors();
    add_vec(32'h0022_1820, 32'h0040_0000, mips_pkg::BR_NONE, 1, 2, 3, 0, 6'h20, 0, 1,
            32'h0000_0000, 0, 32'h0, 32'h0, 0, 32'h0);              // ADD r3, r1, r2
    add_vec(32'h0007_3140, 32'h0040_0004, mips_pkg::BR_NONE, 0, 7, 6, 0, 6'h00, 5, 1,
            32'h0000_0000, 0, 32'h0, 32'h0, 0, 32'h0);              // SLL r6, r7, 5
    add_vec(32'h2128_FFFC, 32'h0040_0008, mips_pkg::BR_NONE, 9, 8, 0, 0, 6'h00, 0, 0,
            32'hFFFF_FFFC, 0, 32'h0, 32'h0, 0, 32'h0);              // ADDI, negative
    add_vec(32'h8D6A_8000, 32'h0040_000C, mips_pkg::BR_NONE, 11, 10, 0, 0, 6'h00, 0, 0,
            32'hFFFF_8000, 0, 32'h0, 32'h0, 0, 32'h0);              // LW, sign extended
    add_vec(32'h35AC_8001, 32'h0040_0010, mips_pkg::BR_NONE, 13, 12, 0, 0, 6'h00, 0, 0,
            32'h0000_8001, 0, 32'h0, 32'h0, 0, 32'h0);              // ORI, zero extended
    add_vec(32'h0810_0040, 32'h9000_0100, mips_pkg::BR_J, 0, 0, 0, 0, 6'h00, 0, 0,
            32'h0000_0000, 1, 32'h9040_0100, 32'h0, 0, 32'h0);
    add_vec(32'h0C00_0010, 32'h1FFF_FFFC, mips_pkg::BR_JAL, 0, 0, 0, 31, 6'h00, 0, 0,
            32'h0000_0000, 1, 32'h2000_0040, 32'h2000_0004, 0, 32'h0); // Region from PC+4
    add_vec(32'h03E0_0008, 32'h0040_0200, mips_pkg::BR_JR, 31, 0, 0, 0, 6'h00, 0, 1,
            32'h0000_0000, 1, 32'h0040_00F0, 32'h0, 0, 32'h0);
    add_vec(32'h01C0_F009, 32'h0040_0300, mips_pkg::BR_JALR, 14, 0, 30, 30, 6'h00, 0, 1,
            32'h0000_0000, 1, 32'h0040_0070, 32'h0040_0308, 0, 32'h0);
    add_vec(32'h1109_0010, 32'h0040_0400, mips_pkg::BR_BEQ, 8, 9, 0, 0, 6'h00, 0, 0,
            32'h0000_0010, 1, 32'h0040_0444, 32'h0, 0, 32'h0);      // Equal operands
    add_vec(32'h110A_FFFD, 32'h0040_0500, mips_pkg::BR_BEQ, 8, 10, 0, 0, 6'h00, 0, 0,
            32'hFFFF_FFFD, 0, 32'h0040_04F8, 32'h0, 0, 32'h0);
    add_vec(32'h150A_FFFF, 32'h0040_0600, mips_pkg::BR_BNE, 8, 10, 0, 0, 6'h00, 0, 0,
            32'hFFFF_FFFF, 1, 32'h0040_0600, 32'h0, 0, 32'h0);
    add_vec(32'h1443_0008, 32'h0040_0700, mips_pkg::BR_BNE, 2, 3, 0, 0, 6'h00, 0, 0,
            32'h0000_0008, 0, 32'h0040_0724, 32'h0, 0, 32'h0);
    add_vec(32'h020F_8820, 32'h0040_0704, mips_pkg::BR_NONE, 16, 15, 17, 0, 6'h20, 0, 1,
            32'h0000_0000, 0, 32'h0, 32'h0, 16, 32'hDEAD_BEEF);     // Write-through on rs
    add_vec(32'h1611_0001, 32'h0040_0800, mips_pkg::BR_BNE, 16, 17, 0, 0, 6'h00, 0, 0,
            32'h0000_0001, 1, 32'h0040_0808, 32'h0, 0, 32'h0);
    add_vec(32'h3AB4_FFFF, 32'h0040_0804, mips_pkg::BR_NONE, 21, 20, 0, 0, 6'h00, 0, 0,
            32'h0000_FFFF, 0, 32'h0, 32'h0, 0, 32'h0);              // XORI
endtask

/* bench/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    localparam int CREDITS   = 4;
    localparam int MAX_DELAY = 3;   // Two LFSR bits per credit return

    typedef struct packed {
        logic [31:0]        instr;
        logic [31:0]        pc;
        mips_pkg::br_kind_e kind;
        logic [4:0]         rs;
        logic [4:0]         rt;
        logic [4:0]         rd;
        logic [4:0]         link_reg;
        logic [5:0]         funct;
        logic [4:0]         sa;
        logic               is_rtype;
        logic [31:0]        ext_imm;
        logic               taken;
        logic [31:0]        target;
        logic [31:0]        link_val;
        mips_pkg::wb_s      wb;
    } vec_s;

    `include "decode_vectors.svh"

    localparam int TIMEOUT = N_VEC * (CREDITS + MAX_DELAY + 2) + 50;

    logic             i_clk = 1'b0;
    logic             i_reset;
    logic             i_instr_valid;
    mips_pkg::instr_u i_instr;
    logic [31:0]      i_pc;
    mips_pkg::wb_s    i_wb;
    logic             i_credit_return;
    logic             o_instr_ready;
    logic             o_op_valid;
    mips_pkg::op_s    o_op;

    vec_s        vecs [N_VEC];
    logic [31:0] reg_model [32];
    int          n_loaded = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_returned = 0;
    int          cur_entry = 0;
    int          cycle = 0;
    int          ret_delay;
    int          due_q [$];
    logic        hold_returns = 1'b0;
    logic [31:0] lfsr = 32'h9225_c05b;

    decode_stage_top #(
        .CREDITS (CREDITS)
    ) dut_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_instr_valid   (i_instr_valid),
        .i_instr         (i_instr),
        .i_pc            (i_pc),
        .i_wb            (i_wb),
        .i_credit_return (i_credit_return),
        .o_instr_ready   (o_instr_ready),
        .o_op_valid      (o_op_valid),
        .o_op            (o_op)
    );

    always #2 i_clk = ~i_clk;

    task automatic add_vec(input logic [31:0] instr, input logic [31:0] pc,
                           input mips_pkg::br_kind_e kind, input logic [4:0] rs,
                           input logic [4:0] rt, input logic [4:0] rd,
                           input logic [4:0] link_reg, input logic [5:0] funct,
                           input logic [4:0] sa, input logic is_rtype,
                           input logic [31:0] ext_imm,
                           input logic taken, input logic [31:0] target,
                           input logic [31:0] link_val, input logic [4:0] wb_addr,
                           input logic [31:0] wb_data);
        vecs[n_loaded] = '{instr, pc, kind, rs, rt, rd, link_reg, funct, sa, is_rtype,
                           ext_imm, taken, target, link_val,
                           '{wb_addr != 5'd0, wb_addr, wb_data}};
        n_loaded++;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] preload_val(input int idx);
        return 32'h0040_0000 + 32'((idx / 2) * 16);     // Pairs of equal registers
    endfunction

    // Same-cycle write wins over the stored register value
    function automatic logic [31:0] exp_reg(input logic [4:0] addr, input mips_pkg::wb_s wb);
        if (addr == 5'd0) begin
            return 32'h0;
        end
        if (wb.valid && wb.addr == addr) begin
            return wb.data;
        end
        return reg_model[addr];
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0t: entry %0d %s got %h expected %h",
                     $time, cur_entry, what, got, exp);
        end
    endtask

    task automatic check_op(input int k);
        vec_s v;
        v = vecs[k];
        cur_entry = k;
        if (!o_op_valid) begin
            n_errors++;
            $display("No o_op_valid in the cycle after entry %0d was accepted", k);
        end else begin
            check_val("br_kind", 32'(o_op.dec.br_kind), 32'(v.kind));
            check_val("rs", 32'(o_op.dec.rs), 32'(v.rs));
            check_val("rt", 32'(o_op.dec.rt), 32'(v.rt));
            check_val("rd", 32'(o_op.dec.rd), 32'(v.rd));
            check_val("link_reg", 32'(o_op.dec.link_reg), 32'(v.link_reg));
            check_val("funct", 32'(o_op.dec.funct), 32'(v.funct));
            check_val("sa", 32'(o_op.dec.sa), 32'(v.sa));
            check_val("is_rtype", 32'(o_op.dec.is_rtype), 32'(v.is_rtype));
            check_val("ext_imm", o_op.dec.ext_imm, v.ext_imm);
            check_val("pc", o_op.pc, v.pc);
            check_val("rs_val", o_op.rs_val, exp_reg(v.rs, v.wb));
            check_val("rt_val", o_op.rt_val, exp_reg(v.rt, v.wb));
            check_val("taken", 32'(o_op.taken), 32'(v.taken));
            check_val("target", o_op.target, v.target);
            check_val("link_val", o_op.link_val, v.link_val);
        end
    endtask

    task automatic report_unexpected();
        n_errors++;
        $display("Unexpected o_op_valid with no instruction accepted the cycle before");
    endtask

    always @(posedge i_clk) begin
        cycle++;
        if (cycle >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Downstream queue model that frees each slot after a random delay
    always @(negedge i_clk) begin
        if (o_op_valid && !i_reset) begin
            ret_delay = 0;
            repeat (2) begin
                ret_delay = (ret_delay << 1) | int'(lfsr[0]);
                lfsr = lfsr_next(lfsr);
            end
            due_q.push_back(cycle + 1 + ret_delay);
        end
        if (!hold_returns && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            n_returned++;
            i_credit_return = 1'b1;
        end else begin
            i_credit_return = 1'b0;
        end
    end

    initial begin : main_seq
        int   idx;
        int   pend_idx;
        int   n_acc;
        int   stall;
        logic pend;
        i_reset = 1'b1;
        i_instr_valid = 1'b0;
        i_instr = '0;
        i_pc = '0;
        i_wb = '0;
        i_credit_return = 1'b0;
        load_vectors();
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;
        #1;
        check_val("o_instr_ready after reset", 32'(o_instr_ready), 32'd1);
        check_val("o_op_valid after reset", 32'(o_op_valid), 32'd0);
        for (int r = 0; r < 32; r++) begin             // r0 is written too and must stay zero
            @(negedge i_clk);
            i_wb = '{1'b1, 5'(r), preload_val(r)};
            reg_model[r] = preload_val(r);
        end
        idx = 0;
        n_acc = 0;
        stall = 0;
        pend = 1'b0;
        pend_idx = 0;
        hold_returns = 1'b1;                            // Start with returns withheld
        while (idx < N_VEC || pend) begin
            @(negedge i_clk);
            i_wb = pend ? vecs[pend_idx].wb : '0;
            i_instr_valid = (idx < N_VEC);
            if (idx < N_VEC) begin
                i_instr = vecs[idx].instr;
                i_pc = vecs[idx].pc;
            end
            #1;
            if (pend) begin
                check_op(pend_idx);
                if (vecs[pend_idx].wb.valid) begin
                    reg_model[vecs[pend_idx].wb.addr] = vecs[pend_idx].wb.data;
                end
            end else if (o_op_valid) begin
                report_unexpected();
            end
            if (hold_returns) begin
                check_val("o_instr_ready with returns held", 32'(o_instr_ready),
                          32'(n_acc < CREDITS));
                if (n_acc >= CREDITS) begin
                    stall++;
                    hold_returns = (stall < 3);
                end
            end
            pend = i_instr_valid && o_instr_ready;
            if (pend) begin
                pend_idx = idx;
                idx++;
                n_acc++;
            end
        end
        i_instr_valid = 1'b0;
        while (n_returned < N_VEC) begin
            @(negedge i_clk);
            i_wb = '0;
            #1;
            if (o_op_valid) begin
                report_unexpected();
            end
        end
        @(negedge i_clk);
        #1;
        check_val("o_instr_ready after all credits returned", 32'(o_instr_ready), 32'd1);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/decode_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_top #(
    parameter int CREDITS = 4
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_instr_valid,
    input  mips_pkg::instr_u i_instr,
    input  logic [31:0]      i_pc,
    input  mips_pkg::wb_s    i_wb,
    input  logic             i_credit_return,
    output logic             o_instr_ready,
    output logic             o_op_valid,
    output mips_pkg::op_s    o_op
);

    mips_pkg::instr_u stage_instr;
    mips_pkg::dec_s   dec;
    logic [31:0]      stage_pc;
    logic [31:0]      rs_val;
    logic [31:0]      rt_val;
    logic             taken;
    logic [31:0]      target;
    logic [31:0]      link_val;

    issue_credit #(
        .CREDITS (CREDITS)
    ) issue_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_instr_valid   (i_instr_valid),
        .i_instr         (i_instr),
        .i_pc            (i_pc),
        .i_credit_return (i_credit_return),
        .o_instr_ready   (o_instr_ready),
        .o_stage_instr   (stage_instr),
        .o_stage_pc      (stage_pc),
        .o_stage_valid   (o_op_valid)
    );

    instr_decode decode_i (
        .i_instr (stage_instr),
        .o_dec   (dec)
    );

    reg_file regs_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wb      (i_wb),
        .i_rs_addr (dec.rs),
        .i_rt_addr (dec.rt),
        .o_rs_val  (rs_val),
        .o_rt_val  (rt_val)
    );

    branch_resolve branch_i (
        .i_dec      (dec),
        .i_pc       (stage_pc),
        .i_rs_val   (rs_val),
        .i_rt_val   (rt_val),
        .o_taken    (taken),
        .o_target   (target),
        .o_link_val (link_val)
    );

    assign o_op = '{dec: dec, rs_val: rs_val, rt_val: rt_val, pc: stage_pc,
                    taken: taken, target: target, link_val: link_val};

endmodule

`default_nettype wire

/* rtl/issue_credit.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_credit #(
    parameter int CREDITS = 4
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_instr_valid,
    input  mips_pkg::instr_u i_instr,
    input  logic [31:0]      i_pc,
    input  logic             i_credit_return,
    output logic             o_instr_ready,
    output mips_pkg::instr_u o_stage_instr,
    output logic [31:0]      o_stage_pc,
    output logic             o_stage_valid
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          accept;

    // A returning credit can be spent in the same cycle
    assign o_instr_ready = (credit_cnt != '0) || i_credit_return;
    assign accept        = i_instr_valid && o_instr_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            credit_cnt    <= CW'(CREDITS);
            o_stage_valid <= 1'b0;
        end else begin
            o_stage_valid <= accept;    // One-cycle issue pulse
            case ({accept, i_credit_return})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: begin
                    if (credit_cnt != CW'(CREDITS)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                default: begin          // Both or neither
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_stage_instr <= i_instr;
            o_stage_pc    <= i_pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
    input  mips_pkg::dec_s i_dec,
    input  logic [31:0]    i_pc,
    input  logic [31:0]    i_rs_val,
    input  logic [31:0]    i_rt_val,
    output logic           o_taken,
    output logic [31:0]    o_target,
    output logic [31:0]    o_link_val
);

    logic [31:0] pc_plus4;
    logic [31:0] pc_plus8;
    logic [31:0] br_target;
    logic [31:0] j_target;
    logic        ops_equal;

    assign pc_plus4  = i_pc + 32'd4;
    assign pc_plus8  = i_pc + 32'd8;                            // Return address
    assign br_target = pc_plus4 + {i_dec.ext_imm[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], i_dec.target26, 2'b00}; // Region jump
    assign ops_equal = (i_rs_val == i_rt_val);

    always_comb begin
        o_taken    = 1'b0;
        o_target   = '0;
        o_link_val = '0;
        case (i_dec.br_kind)
            mips_pkg::BR_J: begin
                o_taken  = 1'b1;
                o_target = j_target;
            end
            mips_pkg::BR_JAL: begin
                o_taken    = 1'b1;
                o_target   = j_target;
                o_link_val = pc_plus8;
            end
            mips_pkg::BR_JR: begin
                o_taken  = 1'b1;
                o_target = i_rs_val;
            end
            mips_pkg::BR_JALR: begin
                o_taken    = 1'b1;
                o_target   = i_rs_val;
                o_link_val = pc_plus8;
            end
            mips_pkg::BR_BEQ: begin
                o_taken  = ops_equal;
                o_target = br_target;
            end
            mips_pkg::BR_BNE: begin
                o_taken  = !ops_equal;
                o_target = br_target;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic          i_clk,
    input  logic          i_reset,
    input  mips_pkg::wb_s i_wb,
    input  logic [4:0]    i_rs_addr,
    input  logic [4:0]    i_rt_addr,
    output logic [31:0]   o_rs_val,
    output logic [31:0]   o_rt_val
);

    logic [31:0] regs [1:31];   // r0 is not stored
    logic        wr_en;

    assign wr_en = i_wb.valid && (i_wb.addr != 5'd0);

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (wr_en && (i_wb.addr == addr)) begin
            val = i_wb.data;                // Write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    always_comb begin
        o_rs_val = read_port(i_rs_addr);
        o_rt_val = read_port(i_rt_addr);
    end

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  mips_pkg::instr_u i_instr,
    output mips_pkg::dec_s   o_dec
);

    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic        zext_op;

    assign imm_sext = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
    assign imm_zext = {16'b0, i_instr.i.imm};

    // Logical immediates take a zero-extended operand
    assign zext_op = (i_instr.i.op == mips_pkg::OP_ANDI) ||
                     (i_instr.i.op == mips_pkg::OP_ORI) ||
                     (i_instr.i.op == mips_pkg::OP_XORI);

    always_comb begin
        o_dec = '0;                                     // Unused fields read zero
        case (i_instr.r.op)
            mips_pkg::OP_RTYPE: begin
                o_dec.is_rtype = 1'b1;
                o_dec.rs       = i_instr.r.rs;
                case (i_instr.r.funct)
                    mips_pkg::FN_JR: begin
                        o_dec.br_kind = mips_pkg::BR_JR;
                    end
                    mips_pkg::FN_JALR: begin
                        o_dec.br_kind  = mips_pkg::BR_JALR;
                        o_dec.rd       = i_instr.r.rd;
                        o_dec.link_reg = i_instr.r.rd;  // Link goes to rd
                    end
                    default: begin                      // Plain ALU op
                        o_dec.funct = i_instr.r.funct;
                        o_dec.rt    = i_instr.r.rt;
                        o_dec.rd    = i_instr.r.rd;
                        o_dec.sa    = i_instr.r.sa;
                    end
                endcase
            end
            mips_pkg::OP_J: begin
                o_dec.target26 = i_instr.j.target;
                o_dec.br_kind  = mips_pkg::BR_J;
            end
            mips_pkg::OP_JAL: begin
                o_dec.target26 = i_instr.j.target;
                o_dec.br_kind  = mips_pkg::BR_JAL;
                o_dec.link_reg = 5'd31;                 // GPR 31
            end
            mips_pkg::OP_BEQ: begin
                o_dec.rs      = i_instr.i.rs;
                o_dec.rt      = i_instr.i.rt;
                o_dec.ext_imm = imm_sext;
                o_dec.br_kind = mips_pkg::BR_BEQ;
            end
            mips_pkg::OP_BNE: begin
                o_dec.rs      = i_instr.i.rs;
                o_dec.rt      = i_instr.i.rt;
                o_dec.ext_imm = imm_sext;
                o_dec.br_kind = mips_pkg::BR_BNE;
            end
            default: begin                              // Loads, stores, ALU immediates
                o_dec.rs      = i_instr.i.rs;
                o_dec.rt      = i_instr.i.rt;
                o_dec.ext_imm = zext_op ? imm_zext : imm_sext;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;

    // R-type function codes
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [5:0]  funct;
    } r_fmt_s;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_s;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_fmt_s;

    // One fetched word, three ways to read it
    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
        j_fmt_s j;
    } instr_u;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_J    = 3'd1,
        BR_JAL  = 3'd2,
        BR_JR   = 3'd3,
        BR_JALR = 3'd4,
        BR_BEQ  = 3'd5,
        BR_BNE  = 3'd6
    } br_kind_e;

    typedef struct packed {
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [31:0] ext_imm;
        logic [25:0] target26;
        br_kind_e    br_kind;
        logic [4:0]  link_reg;  // 31 for JAL, rd for JALR
        logic        is_rtype;
    } dec_s;

    typedef struct packed {
        dec_s        dec;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic [31:0] link_val;
    } op_s;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_s;

endpackage

`default_nettype wire
